//--- logic/udma_ctrl_pkg.sv
// uDMA filter configuration package with widths, register map and setup structs
`default_nettype none

package udma_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and counts
    //////////////////////////////////////////////////////////////////////

    localparam int L2_AWIDTH_NOAL = 15;  // Start address width, in words
    localparam int TRANS_SIZE     = 15;  // Transfer length width
    localparam int NUM_EVT        = 4;   // Event compare lanes
    localparam int NUM_TX_CH      = 2;   // Filter source channels
    localparam int NUM_PERIPH     = 16;  // Clock-gate and reset enables
    localparam int EVT_WIDTH      = 8;   // One event byte
    localparam int FILT_MODE_W    = 3;   // Filter mode field

    // Field positions inside a channel CFG register
    localparam int CFG_DSIZE_LSB  = 0;
    localparam int CFG_MODE_LSB   = 8;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        REG_CG          = 5'd0,
        REG_CFG_EVT     = 5'd1,
        REG_RST         = 5'd2,
        REG_TX_CH0_ADD  = 5'd4,
        REG_TX_CH0_CFG  = 5'd5,
        REG_TX_CH0_LEN0 = 5'd6,
        REG_TX_CH1_ADD  = 5'd9,
        REG_TX_CH1_CFG  = 5'd10,
        REG_TX_CH1_LEN0 = 5'd11,
        REG_RX_CH_ADD   = 5'd14,
        REG_RX_CH_CFG   = 5'd15,
        REG_RX_CH_LEN0  = 5'd16,
        REG_FILT        = 5'd24,
        REG_FILT_CMD    = 5'd25
    } cfg_addr_t;

    // Register bus request, one transfer per valid cycle
    typedef struct packed {
        logic        valid;
        logic        rwn;   // 1 is a read
        cfg_addr_t   addr;
        logic [31:0] data;
    } cfg_req_t;

    //////////////////////////////////////////////////////////////////////
    // Filter setup
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] start_addr;
        logic [1:0]                datasize;
        logic [1:0]                mode;
        logic [TRANS_SIZE-1:0]     len0;
    } chan_cfg_t;

    typedef struct packed {
        chan_cfg_t [NUM_TX_CH-1:0] tx;
        chan_cfg_t                 rx;
        logic [FILT_MODE_W-1:0]    filter_mode;
    } filter_cfg_t;

    // Commit controller states
    typedef enum logic [1:0] {
        FILT_IDLE,
        FILT_SAMPLE,
        FILT_BUSY
    } filter_state_t;

endpackage

`default_nettype wire

//--- logic/udma_cfg_regs.sv
// uDMA configuration register file with bus decode, readback and event compare
`timescale 1ns/1ps
`default_nettype none

module udma_cfg_regs
    import udma_ctrl_pkg::*;
(
    input  wire                         clk_i,
    input  wire                         rstn_i,

    input  wire cfg_req_t               cfg_req_i,
    output logic [31:0]                 cfg_data_o,

    output logic [NUM_PERIPH-1:0]       cg_value_o,
    output logic [NUM_PERIPH-1:0]       rst_value_o,
    output logic                        cg_core_o,

    input  wire                         event_valid_i,
    input  wire  [EVT_WIDTH-1:0]        event_data_i,
    output logic [NUM_EVT-1:0]          event_o,

    output filter_cfg_t                 staged_cfg_o,
    output logic                        start_req_o
);

    logic [NUM_PERIPH-1:0]              cg_q;
    logic [NUM_PERIPH-1:0]              rst_q;
    logic [NUM_EVT-1:0][EVT_WIDTH-1:0]  cmp_evt_q;
    filter_cfg_t                        staged_q;
    logic                               start_req_q;

    logic                               wr_en;
    logic                               rd_en;
    logic [31:0]                        wr_data;

    assign wr_en   = cfg_req_i.valid & ~cfg_req_i.rwn;
    assign rd_en   = cfg_req_i.valid &  cfg_req_i.rwn;
    assign wr_data = cfg_req_i.data;

    assign cg_value_o   = cg_q;
    assign rst_value_o  = rst_q;
    assign cg_core_o    = |cg_q;  // Top enable when any peripheral runs
    assign staged_cfg_o = staged_q;
    assign start_req_o  = start_req_q;

    //////////////////////////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cg_q        <= '0;
            rst_q       <= '0;
            cmp_evt_q   <= '0;
            staged_q    <= '0;
            start_req_q <= 1'b0;
        end
        else
        begin
            // One-cycle request, seen by the commit FSM next cycle
            start_req_q <= wr_en && (cfg_req_i.addr == REG_FILT_CMD) && wr_data[0];

            if (wr_en)
            begin
                case (cfg_req_i.addr)
                    REG_CG:
                        cg_q <= wr_data[NUM_PERIPH-1:0];
                    REG_RST:
                        rst_q <= wr_data[NUM_PERIPH-1:0];
                    REG_CFG_EVT:
                        cmp_evt_q <= wr_data[NUM_EVT*EVT_WIDTH-1:0];  // Lane 0 low byte
                    REG_TX_CH0_ADD:
                        staged_q.tx[0].start_addr <= wr_data[L2_AWIDTH_NOAL-1:0];
                    REG_TX_CH0_CFG:
                    begin
                        staged_q.tx[0].datasize <= wr_data[CFG_DSIZE_LSB+:2];
                        staged_q.tx[0].mode     <= wr_data[CFG_MODE_LSB+:2];
                    end
                    REG_TX_CH0_LEN0:
                        staged_q.tx[0].len0 <= wr_data[TRANS_SIZE-1:0];
                    REG_TX_CH1_ADD:
                        staged_q.tx[1].start_addr <= wr_data[L2_AWIDTH_NOAL-1:0];
                    REG_TX_CH1_CFG:
                    begin
                        staged_q.tx[1].datasize <= wr_data[CFG_DSIZE_LSB+:2];
                        staged_q.tx[1].mode     <= wr_data[CFG_MODE_LSB+:2];
                    end
                    REG_TX_CH1_LEN0:
                        staged_q.tx[1].len0 <= wr_data[TRANS_SIZE-1:0];
                    REG_RX_CH_ADD:
                        staged_q.rx.start_addr <= wr_data[L2_AWIDTH_NOAL-1:0];
                    REG_RX_CH_CFG:
                    begin
                        staged_q.rx.datasize <= wr_data[CFG_DSIZE_LSB+:2];
                        staged_q.rx.mode     <= wr_data[CFG_MODE_LSB+:2];
                    end
                    REG_RX_CH_LEN0:
                        staged_q.rx.len0 <= wr_data[TRANS_SIZE-1:0];
                    REG_FILT:
                        staged_q.filter_mode <= wr_data[FILT_MODE_W-1:0];
                    default:
                        ;  // Unmapped and FILT_CMD hold no data
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        cfg_data_o = '0;
        if (rd_en)
        begin
            case (cfg_req_i.addr)
                REG_CG:
                    cfg_data_o[NUM_PERIPH-1:0] = cg_q;
                REG_RST:
                    cfg_data_o[NUM_PERIPH-1:0] = rst_q;
                REG_CFG_EVT:
                    cfg_data_o[NUM_EVT*EVT_WIDTH-1:0] = cmp_evt_q;
                REG_TX_CH0_ADD:
                    cfg_data_o[L2_AWIDTH_NOAL-1:0] = staged_q.tx[0].start_addr;
                REG_TX_CH0_CFG:
                begin
                    cfg_data_o[CFG_DSIZE_LSB+:2] = staged_q.tx[0].datasize;
                    cfg_data_o[CFG_MODE_LSB+:2]  = staged_q.tx[0].mode;
                end
                REG_TX_CH0_LEN0:
                    cfg_data_o[TRANS_SIZE-1:0] = staged_q.tx[0].len0;
                REG_TX_CH1_ADD:
                    cfg_data_o[L2_AWIDTH_NOAL-1:0] = staged_q.tx[1].start_addr;
                REG_TX_CH1_CFG:
                begin
                    cfg_data_o[CFG_DSIZE_LSB+:2] = staged_q.tx[1].datasize;
                    cfg_data_o[CFG_MODE_LSB+:2]  = staged_q.tx[1].mode;
                end
                REG_TX_CH1_LEN0:
                    cfg_data_o[TRANS_SIZE-1:0] = staged_q.tx[1].len0;
                REG_RX_CH_ADD:
                    cfg_data_o[L2_AWIDTH_NOAL-1:0] = staged_q.rx.start_addr;
                REG_RX_CH_CFG:
                begin
                    cfg_data_o[CFG_DSIZE_LSB+:2] = staged_q.rx.datasize;
                    cfg_data_o[CFG_MODE_LSB+:2]  = staged_q.rx.mode;
                end
                REG_RX_CH_LEN0:
                    cfg_data_o[TRANS_SIZE-1:0] = staged_q.rx.len0;
                REG_FILT:
                    cfg_data_o[FILT_MODE_W-1:0] = staged_q.filter_mode;
                default:
                    cfg_data_o = '0;  // FILT_CMD and holes
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Event compare
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < NUM_EVT; i++)
        begin
            event_o[i] = event_valid_i & (event_data_i == cmp_evt_q[i]);
        end
    end

endmodule

`default_nettype wire

//--- logic/udma_filter_commit.sv
// Filter commit controller that latches the staged setup and pulses filter start
`timescale 1ns/1ps
`default_nettype none

module udma_filter_commit
    import udma_ctrl_pkg::*;
(
    input  wire                 clk_i,
    input  wire                 rstn_i,

    input  wire filter_cfg_t    staged_cfg_i,
    input  wire                 start_req_i,
    input  wire                 filter_done_i,

    output filter_cfg_t         filter_cfg_o,
    output logic                cfg_filter_start_o
);

    filter_state_t  state_q;
    filter_state_t  state_d;
    logic           pending_q;
    logic           pending_d;
    logic           commit;
    logic           start_q;
    filter_cfg_t    committed_q;

    assign filter_cfg_o       = committed_q;
    assign cfg_filter_start_o = start_q;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_d   = state_q;
        pending_d = pending_q;
        commit    = 1'b0;

        case (state_q)
            FILT_IDLE:
            begin
                if (start_req_i)
                begin
                    commit  = 1'b1;
                    state_d = FILT_SAMPLE;
                end
            end
            FILT_SAMPLE:
            begin
                state_d = FILT_BUSY;  // Pulse goes out from this edge
            end
            FILT_BUSY:
            begin
                if (filter_done_i && (start_req_i || pending_q))
                begin
                    // Staged copy already holds the newest setup
                    commit    = 1'b1;
                    pending_d = 1'b0;
                    state_d   = FILT_SAMPLE;
                end
                else if (filter_done_i)
                begin
                    state_d = FILT_IDLE;
                end
                else if (start_req_i)
                begin
                    pending_d = 1'b1;  // Wait for current run
                end
            end
            default:
            begin
                state_d = FILT_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State, pending flag, start pulse and committed setup
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q   <= FILT_IDLE;
            pending_q <= 1'b0;
            start_q   <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            pending_q <= pending_d;
            start_q   <= (state_q == FILT_SAMPLE);  // Exactly one cycle
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            committed_q <= '0;
        end
        else if (commit)
        begin
            committed_q <= staged_cfg_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/udma_ctrl.sv
// uDMA filter configuration top joining the register file and commit controller
`timescale 1ns/1ps
`default_nettype none

module udma_ctrl
    import udma_ctrl_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rstn_i,

    // Register bus
    input  wire cfg_req_t           cfg_req_i,
    output logic [31:0]             cfg_data_o,

    // Peripheral enables
    output logic [NUM_PERIPH-1:0]   cg_value_o,
    output logic [NUM_PERIPH-1:0]   rst_value_o,
    output logic                    cg_core_o,

    // Events
    input  wire                     event_valid_i,
    input  wire  [EVT_WIDTH-1:0]    event_data_i,
    output logic [NUM_EVT-1:0]      event_o,

    // Filter
    input  wire                     filter_done_i,
    output filter_cfg_t             filter_cfg_o,
    output logic                    cfg_filter_start_o
);

    filter_cfg_t    staged_cfg;
    logic           start_req;

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    udma_cfg_regs i_cfg_regs (
        .clk_i          ( clk_i         ),
        .rstn_i         ( rstn_i        ),
        .cfg_req_i      ( cfg_req_i     ),
        .cfg_data_o     ( cfg_data_o    ),
        .cg_value_o     ( cg_value_o    ),
        .rst_value_o    ( rst_value_o   ),
        .cg_core_o      ( cg_core_o     ),
        .event_valid_i  ( event_valid_i ),
        .event_data_i   ( event_data_i  ),
        .event_o        ( event_o       ),
        .staged_cfg_o   ( staged_cfg    ),
        .start_req_o    ( start_req     )
    );

    //////////////////////////////////////////////////////////////////////
    // Commit controller
    //////////////////////////////////////////////////////////////////////

    udma_filter_commit i_filter_commit (
        .clk_i              ( clk_i              ),
        .rstn_i             ( rstn_i             ),
        .staged_cfg_i       ( staged_cfg         ),  // Bus side copy
        .start_req_i        ( start_req          ),
        .filter_done_i      ( filter_done_i      ),
        .filter_cfg_o       ( filter_cfg_o       ),
        .cfg_filter_start_o ( cfg_filter_start_o )
    );

endmodule

`default_nettype wire

//--- testbench/tb_udma_ctrl_tasks.svh
// Bus driver, compare and directed test tasks for the uDMA filter configuration testbench
`ifndef TB_UDMA_CTRL_TASKS_SVH
`define TB_UDMA_CTRL_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
        err_cnt++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic compare_half(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp)
    begin
        err_cnt++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        err_cnt++;
        $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

task automatic compare_evt(input string name, input logic [NUM_EVT-1:0] exp,
                           input logic [NUM_EVT-1:0] act);
    if (act !== exp)
    begin
        err_cnt++;
        $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

task automatic compare_filter(input string name, input filter_cfg_t exp, input filter_cfg_t act);
    if (act !== exp)
    begin
        err_cnt++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
    begin
        pass_cnt++;
        $display("%0t test %s: passed", $time, name);
    end
    else
    begin
        fail_cnt++;
        $display("%0t test %s: failed with %0d errors", $time, name, err_cnt - errs_before);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Bus access and register model
//////////////////////////////////////////////////////////////////////

// Bits that a register keeps, from the field layout of the register map
function automatic logic [31:0] field_mask(input cfg_addr_t addr);
    case (addr)
        REG_CG, REG_RST: return 32'h0000_ffff;
        REG_CFG_EVT: return 32'hffff_ffff;
        REG_TX_CH0_ADD, REG_TX_CH1_ADD, REG_RX_CH_ADD: return 32'h0000_7fff;
        REG_TX_CH0_LEN0, REG_TX_CH1_LEN0, REG_RX_CH_LEN0: return 32'h0000_7fff;
        REG_TX_CH0_CFG, REG_TX_CH1_CFG, REG_RX_CH_CFG: return 32'h0000_0303;
        REG_FILT: return 32'h0000_0007;
        default: return 32'h0;
    endcase
endfunction

task automatic model_write(input cfg_addr_t addr, input logic [31:0] data);
    case (addr)
        REG_CG: cg_model = data[15:0];
        REG_RST: rst_model = data[15:0];
        REG_CFG_EVT: cmp_model = data;
        REG_TX_CH0_ADD: staged_model.tx[0].start_addr = data[14:0];
        REG_TX_CH0_CFG:
        begin
            staged_model.tx[0].datasize = data[1:0];
            staged_model.tx[0].mode     = data[9:8];
        end
        REG_TX_CH0_LEN0: staged_model.tx[0].len0 = data[14:0];
        REG_TX_CH1_ADD: staged_model.tx[1].start_addr = data[14:0];
        REG_TX_CH1_CFG:
        begin
            staged_model.tx[1].datasize = data[1:0];
            staged_model.tx[1].mode     = data[9:8];
        end
        REG_TX_CH1_LEN0: staged_model.tx[1].len0 = data[14:0];
        REG_RX_CH_ADD: staged_model.rx.start_addr = data[14:0];
        REG_RX_CH_CFG:
        begin
            staged_model.rx.datasize = data[1:0];
            staged_model.rx.mode     = data[9:8];
        end
        REG_RX_CH_LEN0: staged_model.rx.len0 = data[14:0];
        REG_FILT: staged_model.filter_mode = data[2:0];
        default: ;
    endcase
endtask

// Returns on the edge that takes the write
task automatic bus_write(input cfg_addr_t addr, input logic [31:0] data);
    cfg_req_t req;
    req = {1'b1, 1'b0, addr, data};
    @(posedge clk);
    cfg_req <= req;
    @(posedge clk);
    cfg_req <= '0;
endtask

task automatic bus_read(input cfg_addr_t addr, output logic [31:0] data);
    cfg_req_t req;
    req = {1'b1, 1'b1, addr, 32'h0};
    @(posedge clk);
    cfg_req <= req;
    @(negedge clk);
    data = cfg_data;  // Combinational readback
    @(posedge clk);
    cfg_req <= '0;
endtask

task automatic reg_write(input cfg_addr_t addr, input logic [31:0] data);
    bus_write(addr, data);
    model_write(addr, data);
endtask

// Staged registers are the mapped ones from address 4 up
task automatic stage_random_setup();
    cfg_addr_t addr;
    for (int a = 4; a < 25; a++)
    begin
        addr = cfg_addr_t'(a[4:0]);
        if (field_mask(addr) != 0)
            reg_write(addr, $random(seed));
    end
endtask

task automatic drive_event(input logic valid, input logic [7:0] data);
    logic [NUM_EVT-1:0] expected;
    for (int k = 0; k < NUM_EVT; k++)
        expected[k] = valid && (data == cmp_model[k]);
    @(posedge clk);
    event_valid <= valid;
    event_data  <= data;
    @(negedge clk);
    compare_evt("event_o", expected, event_vec);
endtask

task automatic hold_check(input int cycles);
    repeat (cycles)
    begin
        @(negedge clk);
        compare_bit("cfg_filter_start_o", 1'b0, filter_start);
        compare_filter("filter_cfg_o", committed_model, filter_cfg);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic reset_defaults();
    int errs;
    logic [31:0] rdata;
    errs = err_cnt;
    @(negedge clk);
    compare_word("cfg_data_o", 32'h0, cfg_data);  // No read presented
    compare_bit("cg_core_o", 1'b0, cg_core);
    compare_evt("event_o", '0, event_vec);
    compare_bit("cfg_filter_start_o", 1'b0, filter_start);
    for (int a = 0; a < 32; a++)
    begin
        bus_read(cfg_addr_t'(a[4:0]), rdata);
        compare_word($sformatf("cfg_data_o at %0d", a), 32'h0, rdata);
    end
    report_test("reset values", errs);
endtask

task automatic write_readback();
    int errs;
    cfg_addr_t addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    errs = err_cnt;
    for (int a = 0; a < 32; a++)
    begin
        addr  = cfg_addr_t'(a[4:0]);
        wdata = $random(seed);
        if (addr == REG_FILT_CMD)
            wdata[0] = 1'b0;  // No start here
        reg_write(addr, wdata);
        @(negedge clk);
        compare_word("cfg_data_o", 32'h0, cfg_data);  // No read presented
        compare_half("cg_value_o", cg_model, cg_value);
        compare_half("rst_value_o", rst_model, rst_value);
        compare_bit("cg_core_o", |cg_model, cg_core);
        bus_read(addr, rdata);
        compare_word($sformatf("cfg_data_o at %0d", a), wdata & field_mask(addr), rdata);
    end
    report_test("write and readback", errs);
endtask

task automatic event_match();
    int errs;
    logic [7:0] data;
    errs = err_cnt;
    reg_write(REG_CFG_EVT, $random(seed));
    for (int i = 0; i < 16; i++)
    begin
        data = (i < 8) ? cmp_model[i % NUM_EVT] : 8'($random(seed));
        drive_event(~i[2], data);  // Valid high, then low, twice
    end
    @(posedge clk);
    event_valid <= 1'b0;
    report_test("event matching", errs);
endtask

task automatic idle_commit();
    int errs;
    errs = err_cnt;
    stage_random_setup();
    bus_write(REG_FILT_CMD, $random(seed) | 32'h1);
    committed_model = staged_model;
    for (int c = 0; c < 4; c++)
    begin
        @(negedge clk);
        compare_bit("cfg_filter_start_o", c == 2, filter_start);
        if (c >= 2)
            compare_filter("filter_cfg_o", committed_model, filter_cfg);
    end
    stage_random_setup();
    hold_check(4);
    report_test("idle commit", errs);
endtask

task automatic pending_start();
    int errs;
    errs = err_cnt;
    stage_random_setup();
    bus_write(REG_FILT_CMD, 32'h1);
    hold_check(6);
    @(posedge clk);
    filter_done <= 1'b1;
    @(posedge clk);
    filter_done <= 1'b0;
    committed_model = staged_model;
    for (int c = 0; c < 3; c++)
    begin
        @(negedge clk);
        compare_bit("cfg_filter_start_o", c == 1, filter_start);
        compare_filter("filter_cfg_o", committed_model, filter_cfg);
    end
    // Done with nothing pending goes back to idle
    @(posedge clk);
    filter_done <= 1'b1;
    @(posedge clk);
    filter_done <= 1'b0;
    hold_check(4);
    // Idle again, so a new start pulses at the idle latency
    bus_write(REG_FILT_CMD, 32'h1);
    for (int c = 0; c < 4; c++)
    begin
        @(negedge clk);
        compare_bit("cfg_filter_start_o", c == 2, filter_start);
    end
    report_test("pending start", errs);
endtask

`endif

//--- testbench/tb_udma_ctrl.sv
// Testbench for the uDMA filter configuration block with directed register and commit tests
`timescale 1ns/1ps
`default_nettype none

module tb_udma_ctrl
    import udma_ctrl_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;  // Tests need about 300

    logic                           clk;
    logic                           rstn;
    cfg_req_t                       cfg_req;
    logic [31:0]                    cfg_data;
    logic [NUM_PERIPH-1:0]          cg_value;
    logic [NUM_PERIPH-1:0]          rst_value;
    logic                           cg_core;
    logic                           event_valid;
    logic [EVT_WIDTH-1:0]           event_data;
    logic [NUM_EVT-1:0]             event_vec;
    logic                           filter_done;
    filter_cfg_t                    filter_cfg;
    logic                           filter_start;

    // Reference model
    filter_cfg_t                    staged_model;
    filter_cfg_t                    committed_model;
    logic [NUM_PERIPH-1:0]          cg_model;
    logic [NUM_PERIPH-1:0]          rst_model;
    logic [NUM_EVT-1:0][EVT_WIDTH-1:0] cmp_model;

    integer                         seed = 32'h1074_05a1;
    int                             err_cnt = 0;
    int                             pass_cnt = 0;
    int                             fail_cnt = 0;
    int                             cycle_cnt = 0;

    `include "tb_udma_ctrl_tasks.svh"

    udma_ctrl i_dut (
        .clk_i              ( clk           ),
        .rstn_i             ( rstn          ),
        .cfg_req_i          ( cfg_req       ),
        .cfg_data_o         ( cfg_data      ),
        .cg_value_o         ( cg_value      ),
        .rst_value_o        ( rst_value     ),
        .cg_core_o          ( cg_core       ),
        .event_valid_i      ( event_valid   ),
        .event_data_i       ( event_data    ),
        .event_o            ( event_vec     ),
        .filter_done_i      ( filter_done   ),
        .filter_cfg_o       ( filter_cfg    ),
        .cfg_filter_start_o ( filter_start  )
    );

    initial
    begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rstn            = 1'b0;
        cfg_req         = '0;
        event_valid     = 1'b0;
        event_data      = '0;
        filter_done     = 1'b0;
        staged_model    = '0;
        committed_model = '0;
        cg_model        = '0;
        rst_model       = '0;
        cmp_model       = '0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        reset_defaults();
        write_readback();
        event_match();
        idle_commit();
        pending_start();  // Relies on the FSM left busy

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/udma_ctrl_pkg.sv
logic/udma_cfg_regs.sv
logic/udma_filter_commit.sv
logic/udma_ctrl.sv
+incdir+testbench
testbench/tb_udma_ctrl.sv
